// File: include/ex_settings.svh
// Execute stage settings
// widths of the datapath and tag, and the multiplier step size
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////////////////////////

`define EX_XLEN 32          // register / ALU width

`define EX_TAG_BITS 6       // pass-through tag width

//////////////////////////////////////////////////////////////////////
// multiplier
//////////////////////////////////////////////////////////////////////

// multiplier bits consumed per cycle, must divide EX_XLEN
`define EX_MULT_STEP_BITS 8

`endif

// File: design/ex_ops_pkg.sv
// Execute unit operation encodings
// ALU function, operand source selects and multiplier sign modes
package ex_ops_pkg;

	//////////////////////////////////////////////////////////////////////
	// ALU function
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_AND    = 4'h2,
		ALU_OR     = 4'h3,
		ALU_XOR    = 4'h4,
		ALU_SLT    = 4'h5,  // signed compare
		ALU_SLTU   = 4'h6,  // unsigned compare
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha,  // low half
		ALU_MULH   = 4'hb,  // high half, signed x signed
		ALU_MULHSU = 4'hc,  // high half, signed x unsigned
		ALU_MULHU  = 4'hd   // high half, unsigned x unsigned
	} alu_func_t;

	//////////////////////////////////////////////////////////////////////
	// operand sources
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_NPC  = 2'h1,  // pc + 4
		OPA_IS_PC   = 2'h2,
		OPA_IS_ZERO = 2'h3
	} opa_select_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} opb_select_t;

	// multiplier operand signedness
	// bit 0 set: mcand signed, bit 1 set: mplier signed
	typedef enum logic [1:0] {
		MULT_UNSIGNED        = 2'b00,
		MULT_SIGNED_UNSIGNED = 2'b01,
		MULT_SIGNED          = 2'b11
	} mult_sign_t;

endpackage

// File: design/rv32_inst_pkg.sv
// RV32 instruction word helpers
// branch funct3 codes and sign-extended immediates for I, S, B, U and J
package rv32_inst_pkg;

	// funct3 of the conditional branches
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branch_func_t;

	function automatic logic [2:0] inst_funct3(input logic [31:0] inst);
		return inst[14:12];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// immediates, all sign extended from inst[31]
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] imm_i(input logic [31:0] inst);
		return {{20{inst[31]}}, inst[31:20]};  // loads, alu-imm, jalr
	endfunction

	function automatic logic [31:0] imm_s(input logic [31:0] inst);
		return {{20{inst[31]}}, inst[31:25], inst[11:7]};  // stores
	endfunction

	// branch offset, bit 0 always zero
	function automatic logic [31:0] imm_b(input logic [31:0] inst);
		return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	endfunction

	function automatic logic [31:0] imm_u(input logic [31:0] inst);
		return {inst[31:12], 12'b0};  // lui, auipc
	endfunction

	// jal offset
	function automatic logic [31:0] imm_j(input logic [31:0] inst);
		return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

endpackage

// File: design/operand_select.sv
// Operand select
// picks ALU operand A (rs1, next pc, pc, zero) and operand B
// (rs2 or one of the decoded immediates)
`include "ex_settings.svh"

module operand_select (
	input  logic [`EX_XLEN-1:0]     inst,
	input  logic [`EX_XLEN-1:0]     pc,
	input  logic [`EX_XLEN-1:0]     rs1_value,
	input  logic [`EX_XLEN-1:0]     rs2_value,
	input  ex_ops_pkg::opa_select_t opa_select,
	input  ex_ops_pkg::opb_select_t opb_select,
	output logic [`EX_XLEN-1:0]     opa,
	output logic [`EX_XLEN-1:0]     opb
);
	import ex_ops_pkg::*;
	import rv32_inst_pkg::*;

	logic [`EX_XLEN-1:0] npc;

	assign npc = pc + `EX_XLEN'd4;  // sequential next pc

	//////////////////////////////////////////////////////////////////////
	// operand A
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		opa = '0;  // zero also covers OPA_IS_ZERO
		case (opa_select)
			OPA_IS_RS1: opa = rs1_value;
			OPA_IS_NPC: opa = npc;        // jal / jalr link value
			OPA_IS_PC:  opa = pc;         // auipc, branch target
			default:    opa = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// operand B
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		opb = '0;  // undefined selects give zero
		case (opb_select)
			OPB_IS_RS2:   opb = rs2_value;
			OPB_IS_I_IMM: opb = imm_i(inst);
			OPB_IS_S_IMM: opb = imm_s(inst);
			OPB_IS_B_IMM: opb = imm_b(inst);
			OPB_IS_U_IMM: opb = imm_u(inst);
			OPB_IS_J_IMM: opb = imm_j(inst);
			default:      opb = '0;
		endcase
	end

endmodule

// File: design/mult.sv
// Sequential multiplier
// signed, unsigned and mixed operands, double-width product
// consumes EX_MULT_STEP_BITS multiplier bits per cycle
`include "ex_settings.svh"

module mult (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     start,
	input  ex_ops_pkg::mult_sign_t   sign,
	input  logic [`EX_XLEN-1:0]      mcand,
	input  logic [`EX_XLEN-1:0]      mplier,
	output logic [2*`EX_XLEN-1:0]    product,
	output logic                     done
);
	import ex_ops_pkg::*;

	localparam int XLEN     = `EX_XLEN;
	localparam int W2       = 2 * XLEN;
	localparam int STEP     = `EX_MULT_STEP_BITS;
	localparam int STEPS    = XLEN / STEP;
	localparam int CNT_BITS = $clog2(STEPS + 1);

	logic [W2-1:0]       mcand_ext;   // extended multiplicand
	logic [W2-1:0]       correction;  // start value of the accumulator
	logic [W2-1:0]       mcand_q;     // shifted multiplicand
	logic [W2-1:0]       acc;
	logic [XLEN-1:0]     mplier_q;    // remaining multiplier bits
	logic [W2-1:0]       step_mcand;
	logic [W2-1:0]       step_acc;
	logic [XLEN-1:0]     step_mplier;
	logic [W2-1:0]       partial;
	logic [CNT_BITS-1:0] count;       // steps left
	logic                busy;

	assign mcand_ext = (sign != MULT_UNSIGNED) ? {{XLEN{mcand[XLEN-1]}}, mcand}
	                                           : {{XLEN{1'b0}}, mcand};

	// a negative signed multiplier is treated as unsigned minus 2^XLEN,
	// so subtract mcand << XLEN up front
	assign correction = (sign == MULT_SIGNED && mplier[XLEN-1]) ? -(mcand_ext << XLEN)
	                                                            : '0;

	// first step works straight from the inputs
	assign step_mcand  = start ? mcand_ext  : mcand_q;
	assign step_mplier = start ? mplier     : mplier_q;
	assign step_acc    = start ? correction : acc;
	assign partial     = step_mcand * W2'(step_mplier[STEP-1:0]);

	//////////////////////////////////////////////////////////////////////
	// step control
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;  // one-cycle pulse
			if (start) begin
				busy  <= (STEPS > 1);
				count <= CNT_BITS'(STEPS - 1);
				done  <= (STEPS == 1);
			end else if (busy) begin
				count <= count - 1'b1;
				if (count == CNT_BITS'(1)) begin  // last step
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// datapath, accumulate and shift
	always_ff @(posedge clock) begin
		if (start || busy) begin
			acc      <= step_acc + partial;
			mcand_q  <= step_mcand << STEP;
			mplier_q <= step_mplier >> STEP;
		end
	end

	assign product = acc;  // held until the next start

endmodule

// File: design/alu.sv
// ALU
// single-cycle logic, arithmetic, compare and shift functions,
// multiply variants sequenced through mult
`include "ex_settings.svh"

module alu (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  logic [`EX_XLEN-1:0]   opa,
	input  logic [`EX_XLEN-1:0]   opb,
	input  ex_ops_pkg::alu_func_t func,
	output logic                  done,
	output logic [`EX_XLEN-1:0]   result
);
	import ex_ops_pkg::*;

	localparam int XLEN       = `EX_XLEN;
	localparam int SHAMT_BITS = $clog2(XLEN);

	logic                  is_mul;        // func is a multiply
	logic                  want_high;     // high half wanted
	mult_sign_t            mult_sign;
	logic                  mult_start;
	logic                  mult_done;
	logic [2*XLEN-1:0]     product;
	logic                  high_q;        // remembered half
	logic                  mul_done_q;
	logic [XLEN-1:0]       mul_result_q;
	logic [XLEN-1:0]       simple_result;
	logic [SHAMT_BITS-1:0] shamt;

	assign shamt = opb[SHAMT_BITS-1:0];  // low 5 bits only

	//////////////////////////////////////////////////////////////////////
	// multiply decode
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		is_mul    = 1'b1;
		want_high = 1'b1;
		mult_sign = MULT_SIGNED;
		case (func)
			ALU_MUL:    want_high = 1'b0;  // sign irrelevant for low half
			ALU_MULH:   mult_sign = MULT_SIGNED;
			ALU_MULHSU: mult_sign = MULT_SIGNED_UNSIGNED;
			ALU_MULHU:  mult_sign = MULT_UNSIGNED;
			default:    is_mul = 1'b0;
		endcase
	end

	assign mult_start = start & is_mul;

	mult i_mult (
		.clock   (clock),
		.reset   (reset),
		.start   (mult_start),
		.sign    (mult_sign),
		.mcand   (opa),
		.mplier  (opb),
		.product (product),
		.done    (mult_done)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			high_q     <= 1'b0;
			mul_done_q <= 1'b0;
		end else begin
			mul_done_q <= mult_done;  // done one cycle after mult
			if (mult_start)
				high_q <= want_high;
		end
	end

	always_ff @(posedge clock) begin
		if (mult_done)
			mul_result_q <= high_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
	end

	//////////////////////////////////////////////////////////////////////
	// single-cycle functions
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		simple_result = '0;
		case (func)
			ALU_ADD:  simple_result = opa + opb;
			ALU_SUB:  simple_result = opa - opb;
			ALU_AND:  simple_result = opa & opb;
			ALU_OR:   simple_result = opa | opb;
			ALU_XOR:  simple_result = opa ^ opb;
			ALU_SLT:  simple_result = XLEN'($signed(opa) < $signed(opb));
			ALU_SLTU: simple_result = XLEN'(opa < opb);
			ALU_SLL:  simple_result = opa << shamt;
			ALU_SRL:  simple_result = opa >> shamt;
			ALU_SRA:  simple_result = $signed(opa) >>> shamt;  // keeps sign
			default:  simple_result = '0;
		endcase
	end

	assign done   = (start & ~is_mul) | mul_done_q;
	assign result = mul_done_q ? mul_result_q : simple_result;

endmodule

// File: design/brcond.sv
// Branch condition
// RV32 equality and signed / unsigned ordering tests by funct3
`include "ex_settings.svh"

module brcond (
	input  logic [`EX_XLEN-1:0]       rs1,
	input  logic [`EX_XLEN-1:0]       rs2,
	input  rv32_inst_pkg::branch_func_t func,
	output logic                      cond
);
	import rv32_inst_pkg::*;

	always_comb begin
		cond = 1'b0;  // undefined funct3 never branches
		case (func)
			BR_BEQ:  cond = (rs1 == rs2);
			BR_BNE:  cond = (rs1 != rs2);
			BR_BLT:  cond = ($signed(rs1) <  $signed(rs2));
			BR_BGE:  cond = ($signed(rs1) >= $signed(rs2));
			BR_BLTU: cond = (rs1 <  rs2);
			BR_BGEU: cond = (rs1 >= rs2);
			default: cond = 1'b0;
		endcase
	end

endmodule

// File: design/ex_stage.sv
// Execute stage
// four-phase issue and result handshakes around one operation at a time,
// operand select, ALU and branch condition, tag passed through
`include "ex_settings.svh"

module ex_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      issue_req,
	input  logic [`EX_XLEN-1:0]       issue_inst,
	input  logic [`EX_XLEN-1:0]       issue_pc,
	input  logic [`EX_XLEN-1:0]       issue_rs1_value,
	input  logic [`EX_XLEN-1:0]       issue_rs2_value,
	input  ex_ops_pkg::opa_select_t   issue_opa_select,
	input  ex_ops_pkg::opb_select_t   issue_opb_select,
	input  ex_ops_pkg::alu_func_t     issue_alu_func,
	input  logic                      issue_cond_branch,
	input  logic                      issue_uncond_branch,
	input  logic [`EX_TAG_BITS-1:0]   issue_tag,
	output logic                      issue_ack,
	output logic                      result_req,
	output logic [`EX_XLEN-1:0]       result_value,
	output logic                      result_take_branch,
	output logic [`EX_TAG_BITS-1:0]   result_tag,
	input  logic                      result_ack
);
	import ex_ops_pkg::*;
	import rv32_inst_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,     // waiting for issue
		S_EXECUTE,  // alu running
		S_OFFER,    // result_req high
		S_RELEASE   // waiting for result_ack to drop
	} state_t;

	state_t                  state;
	logic                    accept;
	logic                    launch_q;  // first execute cycle
	logic                    start_q;   // alu start pulse

	// captured operation
	logic [`EX_XLEN-1:0]     inst_q, pc_q, rs1_q, rs2_q;
	opa_select_t             opa_select_q;
	opb_select_t             opb_select_q;
	alu_func_t               alu_func_q;
	logic                    cond_branch_q, uncond_branch_q;
	logic [`EX_TAG_BITS-1:0] tag_q;

	logic [`EX_XLEN-1:0]     alu_opa, alu_opb, alu_result;
	logic                    alu_done;
	logic                    br_cond;

	// idle, previous handshakes fully released
	assign accept = (state == S_IDLE) && issue_req && !issue_ack && !result_ack;

	//////////////////////////////////////////////////////////////////////
	// handshake FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= S_IDLE;
			issue_ack  <= 1'b0;
			result_req <= 1'b0;
			launch_q   <= 1'b0;
			start_q    <= 1'b0;
		end else begin
			launch_q <= accept;
			start_q  <= launch_q;  // start one cycle after capture
			if (accept)
				issue_ack <= 1'b1;
			else if (!issue_req)
				issue_ack <= 1'b0;  // release once source drops req
			case (state)
				S_IDLE:
					if (accept) state <= S_EXECUTE;
				S_EXECUTE:
					if (alu_done) begin
						result_req <= 1'b1;
						state      <= S_OFFER;
					end
				S_OFFER:
					if (result_ack) begin
						result_req <= 1'b0;
						state      <= S_RELEASE;
					end
				S_RELEASE:
					if (!result_ack) state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// operation capture and result registers
	always_ff @(posedge clock) begin
		if (accept) begin
			inst_q          <= issue_inst;
			pc_q            <= issue_pc;
			rs1_q           <= issue_rs1_value;
			rs2_q           <= issue_rs2_value;
			opa_select_q    <= issue_opa_select;
			opb_select_q    <= issue_opb_select;
			alu_func_q      <= issue_alu_func;
			cond_branch_q   <= issue_cond_branch;
			uncond_branch_q <= issue_uncond_branch;
			tag_q           <= issue_tag;
		end
		if (state == S_EXECUTE && alu_done) begin
			result_value       <= alu_result;
			result_take_branch <= uncond_branch_q | (cond_branch_q & br_cond);
			result_tag         <= tag_q;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////////////////////////
	operand_select i_operand_select (
		.inst       (inst_q),
		.pc         (pc_q),
		.rs1_value  (rs1_q),
		.rs2_value  (rs2_q),
		.opa_select (opa_select_q),
		.opb_select (opb_select_q),
		.opa        (alu_opa),
		.opb        (alu_opb)
	);

	alu i_alu (
		.clock  (clock),
		.reset  (reset),
		.start  (start_q),
		.opa    (alu_opa),
		.opb    (alu_opb),
		.func   (alu_func_q),
		.done   (alu_done),
		.result (alu_result)
	);

	brcond i_brcond (
		.rs1  (rs1_q),
		.rs2  (rs2_q),
		.func (branch_func_t'(inst_funct3(inst_q))),  // funct3 of the branch
		.cond (br_cond)
	);

endmodule

// File: tb/clock_gen.sv
// Clock and reset source
// 10 ns clock, synchronous reset high over the first 3 rising edges
module clock_gen (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;  // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);  // released mid-cycle
		reset = 1'b0;
	end

endmodule

// File: tb/ex_stage_sva.sv
// Execute stage handshake assertions
// four-phase rules on the issue and result ports, reset values
`include "ex_settings.svh"

module ex_stage_sva (
	input logic                    clock,
	input logic                    reset,
	input logic                    issue_req,
	input logic                    issue_ack,
	input logic                    result_req,
	input logic                    result_ack,
	input logic [`EX_XLEN-1:0]     result_value,
	input logic                    result_take_branch,
	input logic [`EX_TAG_BITS-1:0] result_tag
);
	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////////////////////////
	// result port
	//////////////////////////////////////////////////////////////////////
	result_stable: assert property (@(posedge clock) disable iff (reset)
		result_req && !result_ack |=>
			$stable(result_value) && $stable(result_take_branch) && $stable(result_tag))
		else $error("result fields changed while waiting for result_ack");

	result_held: assert property (@(posedge clock) disable iff (reset)
		result_req && !result_ack |=> result_req)  // no early withdraw
		else $error("result_req dropped before result_ack");

	// issue port, ack only answers a request
	issue_ack_rise: assert property (@(posedge clock) disable iff (reset)
		$rose(issue_ack) |-> $past(issue_req))
		else $error("issue_ack rose while issue_req was low");

	reset_values: assert property (@(posedge clock)
		reset |=> !issue_ack && !result_req)
		else $error("handshake outputs not low after reset");

endmodule

bind ex_stage ex_stage_sva i_ex_stage_sva (
	.clock              (clock),
	.reset              (reset),
	.issue_req          (issue_req),
	.issue_ack          (issue_ack),
	.result_req         (result_req),
	.result_ack         (result_ack),
	.result_value       (result_value),
	.result_take_branch (result_take_branch),
	.result_tag         (result_tag)
);

// File: tb/ex_stage_tb.sv
// Execute stage testbench
// random operations from an LFSR, checked against a reference model,
// random back-pressure on the result port
`include "ex_settings.svh"

module ex_stage_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import ex_ops_pkg::*;

	localparam int XLEN     = `EX_XLEN;
	localparam int TAG_BITS = `EX_TAG_BITS;
	localparam int NUM_OPS  = 400;
	localparam int TIMEOUT  = 100;  // cycles per wait

	logic                clock, reset;
	logic                issue_req, issue_ack;
	logic [XLEN-1:0]     issue_inst, issue_pc, issue_rs1_value, issue_rs2_value;
	opa_select_t         issue_opa_select;
	opb_select_t         issue_opb_select;
	alu_func_t           issue_alu_func;
	logic                issue_cond_branch, issue_uncond_branch;
	logic [TAG_BITS-1:0] issue_tag;
	logic                result_req, result_ack, result_take_branch;
	logic [XLEN-1:0]     result_value;
	logic [TAG_BITS-1:0] result_tag;

	logic [31:0]         lfsr;
	int                  cycle;
	logic [TAG_BITS-1:0] next_tag;
	logic [TAG_BITS-1:0] tag_queue[$];  // issued, not yet returned

	clock_gen i_clock_gen (.clock(clock), .reset(reset));

	ex_stage i_ex_stage (
		.clock (clock), .reset (reset),
		.issue_req (issue_req), .issue_inst (issue_inst), .issue_pc (issue_pc),
		.issue_rs1_value (issue_rs1_value), .issue_rs2_value (issue_rs2_value),
		.issue_opa_select (issue_opa_select), .issue_opb_select (issue_opb_select),
		.issue_alu_func (issue_alu_func), .issue_cond_branch (issue_cond_branch),
		.issue_uncond_branch (issue_uncond_branch), .issue_tag (issue_tag),
		.issue_ack (issue_ack), .result_req (result_req), .result_value (result_value),
		.result_take_branch (result_take_branch), .result_tag (result_tag),
		.result_ack (result_ack)
	);

	//////////////////////////////////////////////////////////////////////
	// random source, Fibonacci LFSR taps 32 22 2 1
	//////////////////////////////////////////////////////////////////////
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};  // one step per bit
		return v;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] model_imm(input opb_select_t kind, input logic [31:0] inst);
		logic [12:0] b_off;
		logic [20:0] j_off;
		logic [31:0] i_val;
		logic [31:0] imm;
		b_off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		j_off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		i_val = $signed(inst) >>> 20;  // top 12 bits, sign extended
		case (kind)
			OPB_IS_I_IMM: imm = i_val;
			OPB_IS_S_IMM: imm = {i_val[31:5], inst[11:7]};
			OPB_IS_B_IMM: imm = {{19{b_off[12]}}, b_off};
			OPB_IS_U_IMM: imm = inst & 32'hffff_f000;
			OPB_IS_J_IMM: imm = {{11{j_off[20]}}, j_off};
			default:      imm = '0;
		endcase
		return imm;
	endfunction

	task automatic model_op(output logic [XLEN-1:0] value, output logic take);
		logic [XLEN-1:0]   a, b, r1, r2;
		logic [2*XLEN-1:0] ea, eb, prod;
		logic              sa, sb, hit;
		r1 = issue_rs1_value;
		r2 = issue_rs2_value;
		case (issue_opa_select)
			OPA_IS_RS1: a = r1;
			OPA_IS_NPC: a = issue_pc + 32'd4;
			OPA_IS_PC:  a = issue_pc;
			default:    a = '0;
		endcase
		b = (issue_opb_select == OPB_IS_RS2) ? r2 : model_imm(issue_opb_select, issue_inst);
		sa = (issue_alu_func == ALU_MULH) || (issue_alu_func == ALU_MULHSU);
		sb = (issue_alu_func == ALU_MULH);
		ea = {{XLEN{a[XLEN-1] & sa}}, a};
		eb = {{XLEN{b[XLEN-1] & sb}}, b};
		prod = ea * eb;  // low 2*XLEN bits right for every sign mode
		value = '0;
		case (issue_alu_func)
			ALU_ADD:  value = a + b;
			ALU_SUB:  value = a - b;
			ALU_AND:  value = a & b;
			ALU_OR:   value = a | b;
			ALU_XOR:  value = a ^ b;
			ALU_SLT:  value[0] = $signed(a) < $signed(b);
			ALU_SLTU: value[0] = a < b;
			ALU_SLL:  value = a << b[4:0];
			ALU_SRL:  value = a >> b[4:0];
			ALU_SRA:  value = $signed(a) >>> b[4:0];
			ALU_MUL:  value = prod[XLEN-1:0];
			default:  value = prod[2*XLEN-1:XLEN];  // mulh, mulhsu, mulhu
		endcase
		case (issue_inst[14:12])  // branch funct3
			3'b000:  hit = (r1 == r2);
			3'b001:  hit = (r1 != r2);
			3'b100:  hit = ($signed(r1) < $signed(r2));
			3'b101:  hit = ($signed(r1) >= $signed(r2));
			3'b110:  hit = (r1 < r2);
			3'b111:  hit = (r1 >= r2);
			default: hit = 1'b0;
		endcase
		take = issue_uncond_branch | (issue_cond_branch & hit);
	endtask

	//////////////////////////////////////////////////////////////////////
	// error reporting and compares
	//////////////////////////////////////////////////////////////////////
	task automatic report_mismatch(input string what);
		$display("FAILED at %0t ns: %s", $time, what);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout at %0t ns: %s", $time, what);
		$display("STATUS: FAIL");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
			input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_tag(input logic [TAG_BITS-1:0] got, input logic [TAG_BITS-1:0] exp,
			input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
			report_mismatch($sformatf("result latency %0d cycles, expected %0d", got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// cycle stepping and waits
	//////////////////////////////////////////////////////////////////////
	task automatic step();
		@(posedge clock);
		#1;  // sample and drive off the edge
		cycle++;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (reset !== 1'b0 && n < TIMEOUT) begin
			step();
			n++;
		end
		if (reset !== 1'b0)
			stop_on_timeout("reset never released");
	endtask

	task automatic wait_issue_ack(input logic level);
		int n;
		n = 0;
		while (issue_ack !== level && n < TIMEOUT) begin
			step();
			n++;
			if (level && result_req)  // nothing pending yet
				report_mismatch("result_req high before the issue was accepted");
		end
		if (issue_ack !== level)
			stop_on_timeout(level ? "issue_ack never rose" : "issue_ack never dropped");
	endtask

	task automatic wait_result_req(input logic level);
		int n;
		n = 0;
		while (result_req !== level && n < TIMEOUT) begin
			step();
			n++;
		end
		if (result_req !== level)
			stop_on_timeout(level ? "result_req never rose" : "result_req never dropped");
	endtask

	//////////////////////////////////////////////////////////////////////
	// one operation through both handshakes
	//////////////////////////////////////////////////////////////////////
	task automatic drive_random_op(input int index, output logic single);
		logic [1:0] kind;
		logic [3:0] f;
		kind = (index == 0) ? 2'd0 : 2'(random_bits(2));  // first op single-cycle
		issue_inst          = random_bits(32);
		issue_pc            = random_bits(32) & ~32'h3;
		issue_rs1_value     = random_bits(32);
		issue_rs2_value     = random_bits(32);
		issue_cond_branch   = 1'b0;
		issue_uncond_branch = 1'b0;
		if (random_bits(2) == 0)
			issue_rs2_value = issue_rs1_value;  // equal compares
		issue_opa_select = opa_select_t'(2'(random_bits(2)));
		issue_opb_select = opb_select_t'(3'(random_bits(3)));  // 6, 7 give zero
		single = (kind != 2'd2);
		case (kind)
			2'd2: begin  // multiply
				f = 4'ha + 4'(random_bits(2));
				issue_alu_func = alu_func_t'(f);
			end
			2'd3: begin  // branch, target pc + B immediate
				issue_opa_select    = OPA_IS_PC;
				issue_opb_select    = OPB_IS_B_IMM;
				issue_alu_func      = ALU_ADD;
				issue_uncond_branch = next_bit();
				issue_cond_branch   = ~issue_uncond_branch;
			end
			default: begin
				f = 4'(random_bits(4));
				if (f > 4'd9)
					f = f - 4'd10;
				issue_alu_func = alu_func_t'(f);
			end
		endcase
		issue_tag = next_tag;
		tag_queue.push_back(next_tag);
		next_tag = next_tag + 1'b1;
	endtask

	task automatic check_result(input logic [XLEN-1:0] value, input logic take,
			input logic [TAG_BITS-1:0] tag);
		check_value(result_value, value, "result_value");
		check_flag(result_take_branch, take, "result_take_branch");
		check_tag(result_tag, tag, "result_tag");
	endtask

	task automatic run_operation(input int index);
		logic [XLEN-1:0]     exp_value;
		logic                exp_take;
		logic                single;
		logic [TAG_BITS-1:0] exp_tag;
		int                  accept_cycle;
		int                  delay;
		drive_random_op(index, single);
		model_op(exp_value, exp_take);
		issue_req = 1'b1;
		wait_issue_ack(1'b1);
		accept_cycle = cycle;
		issue_req = 1'b0;
		issue_inst      = random_bits(32);  // fields free once acked
		issue_rs1_value = random_bits(32);
		issue_tag       = ~issue_tag;
		wait_issue_ack(1'b0);
		wait_result_req(1'b1);
		if (single)
			check_latency(cycle - accept_cycle, 2);
		exp_tag = tag_queue.pop_front();  // oldest issue
		check_result(exp_value, exp_take, exp_tag);
		delay = int'(random_bits(3)) % 7;
		repeat (delay) begin  // back-pressure
			step();
			check_flag(result_req, 1'b1, "result_req under back-pressure");
			check_result(exp_value, exp_take, exp_tag);
		end
		result_ack = 1'b1;
		wait_result_req(1'b0);
		result_ack = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		lfsr                = 32'h0c53_2f9f;
		cycle               = 0;
		next_tag            = '0;
		issue_req           = 1'b0;
		issue_inst          = '0;
		issue_pc            = '0;
		issue_rs1_value     = '0;
		issue_rs2_value     = '0;
		issue_opa_select    = OPA_IS_RS1;
		issue_opb_select    = OPB_IS_RS2;
		issue_alu_func      = ALU_ADD;
		issue_cond_branch   = 1'b0;
		issue_uncond_branch = 1'b0;
		issue_tag           = '0;
		result_ack          = 1'b0;
		wait_reset_release();
		check_flag(issue_ack, 1'b0, "issue_ack after reset");
		check_flag(result_req, 1'b0, "result_req after reset");
		for (int i = 0; i < NUM_OPS; i++)
			run_operation(i);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: sim.f
+incdir+include
design/ex_ops_pkg.sv
design/rv32_inst_pkg.sv
design/operand_select.sv
design/mult.sv
design/alu.sv
design/brcond.sv
design/ex_stage.sv
tb/clock_gen.sv
tb/ex_stage_sva.sv
tb/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
	-f sim.f --top-module ex_stage_tb -o ex_stage_sim

# nonzero exit status on any $fatal or failed assertion
./obj_dir/ex_stage_sim
